//--- hw/fgVideoPkg.sv
//==================================================
// shared timing limits, vector types and FSM enums
// for the foreground video layer; every RTL file
// refers to these by scoped names
//==================================================
`default_nettype none

package fgVideoPkg;

	// vector types with a meaning of their own
	typedef logic [8:0]  pixHT;      // horizontal count
	typedef logic [7:0]  pixVT;      // vertical count
	typedef logic [10:0] vramAddrT;  // {pixV[7:3], pixH[8:3]}
	typedef logic [12:0] charAddrT;  // {bank, code hi, row, code lo, half}
	typedef logic [7:0]  byteT;
	typedef logic [4:0]  colorIdxT;

	typedef enum logic [1:0] {
		REGION_VRAM,
		REGION_CHAR,
		REGION_CTRL
	} hostRegionT;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_WAIT_SLOT,
		ST_WRITE,
		ST_ACK
	} hostStateT;

	//==================================================
	// raster limits
	//==================================================
	localparam int   LINE_CYCLES = 424;
	localparam pixHT H_LAST      = 9'd511;
	localparam pixHT H_START     = pixHT'(H_LAST - LINE_CYCLES + 1);   // 88
	localparam pixHT H_VIS_FIRST = 9'd90;
	localparam pixHT H_VIS_LAST  = 9'd437;
	localparam pixVT V_VIS_FIRST = 8'd16;
	localparam pixVT V_VIS_LAST  = 8'd239;
	localparam pixHT HSYNC_FIRST = 9'd464;   // hsync high here
	localparam pixHT HSYNC_LAST  = 9'd479;
	localparam pixVT VSYNC_FIRST = 8'd248;   // vsync low here
	localparam pixVT VSYNC_LAST  = 8'd251;
	localparam int   PIPE_DEPTH  = 3;        // raw count to colour index

	// blanking compares, used by the timing block and the fetch pipe
	function automatic logic hBlankOf(pixHT h);
		return (h < H_VIS_FIRST) || (h > H_VIS_LAST);
	endfunction

	function automatic logic vBlankOf(pixVT v);
		return (v < V_VIS_FIRST) || (v > V_VIS_LAST);
	endfunction

endpackage

`default_nettype wire

//--- hw/videoTiming.sv
//==================================================
// free running pixel and line counters
// rawBlank follows the live count, the blank and
// sync outputs are delayed to match the pixel pipe
//==================================================
`timescale 1ns/1ns
`default_nettype none

module videoTiming (
	input  wire                clk2_6MHZ,
	input  wire                RAMB,
	output fgVideoPkg::pixHT   pixH_o,
	output fgVideoPkg::pixVT   pixV_o,
	output logic               rawBlank_o,
	output logic               hBlank_o,
	output logic               vBlank_o,
	output logic               hSync_o,
	output logic               vSync_o
);

	fgVideoPkg::pixHT pixH;
	fgVideoPkg::pixVT pixV;

	logic hBlankRaw, vBlankRaw, hSyncRaw, vSyncRaw;

	// {hBlank, vBlank, hSync, vSync} per stage
	logic [3:0] syncDly [fgVideoPkg::PIPE_DEPTH];

	// horizontal 88..511, vertical 0..255
	always_ff @(posedge clk2_6MHZ or negedge RAMB) begin
		if (!RAMB) begin
			pixH <= fgVideoPkg::H_START;
			pixV <= '0;
		end else if (pixH == fgVideoPkg::H_LAST) begin
			pixH <= fgVideoPkg::H_START;
			pixV <= pixV + 8'd1;   // wraps at 255
		end else begin
			pixH <= pixH + 9'd1;
		end
	end

	assign hBlankRaw = fgVideoPkg::hBlankOf(pixH);
	assign vBlankRaw = fgVideoPkg::vBlankOf(pixV);
	assign hSyncRaw  = (pixH >= fgVideoPkg::HSYNC_FIRST) && (pixH <= fgVideoPkg::HSYNC_LAST);
	assign vSyncRaw  = !((pixV >= fgVideoPkg::VSYNC_FIRST) && (pixV <= fgVideoPkg::VSYNC_LAST));

	//==================================================
	// align with fetch (2) + mixer (1)
	//==================================================
	always_ff @(posedge clk2_6MHZ or negedge RAMB) begin
		if (!RAMB) begin
			for (int i = 0; i < fgVideoPkg::PIPE_DEPTH; i++) begin
				syncDly[i] <= 4'b1101;   // blanked, sync idle
			end
		end else begin
			syncDly[0] <= {hBlankRaw, vBlankRaw, hSyncRaw, vSyncRaw};
			for (int i = 1; i < fgVideoPkg::PIPE_DEPTH; i++) begin
				syncDly[i] <= syncDly[i-1];
			end
		end
	end

	assign pixH_o     = pixH;
	assign pixV_o     = pixV;
	assign rawBlank_o = hBlankRaw | vBlankRaw;   // write slot for VRAM

	assign {hBlank_o, vBlank_o, hSync_o, vSync_o} = syncDly[fgVideoPkg::PIPE_DEPTH-1];

endmodule

`default_nettype wire

//--- hw/hostWriteFsm.sv
//==================================================
// four-phase host write port
// CHAR and CTRL writes go straight through, VRAM
// writes wait for a blanking cycle; also holds the
// colour bank and char bank control register
//==================================================
`timescale 1ns/1ns
`default_nettype none

module hostWriteFsm (
	input  wire                      clk2_6MHZ,
	input  wire                      RAMB,
	input  wire                      hostReq_i,
	input  fgVideoPkg::hostRegionT   hostRegion_i,
	input  fgVideoPkg::charAddrT     hostAddr_i,
	input  fgVideoPkg::byteT         hostData_i,
	output logic                     hostAck_o,
	input  wire                      rawBlank_i,
	output logic                     vramWe_o,
	output logic                     charWe_o,
	output fgVideoPkg::charAddrT     wrAddr_o,
	output fgVideoPkg::byteT         wrData_o,
	output logic [1:0]               colorBank_o,
	output logic                     charBank_o
);

	fgVideoPkg::hostStateT  stateQ, stateD;
	fgVideoPkg::hostRegionT regionQ;
	logic                   ctrlWe;

	always_ff @(posedge clk2_6MHZ or negedge RAMB) begin
		if (!RAMB) stateQ <= fgVideoPkg::ST_IDLE;
		else       stateQ <= stateD;
	end

	always_comb begin
		stateD = stateQ;
		case (stateQ)
			fgVideoPkg::ST_IDLE:
				if (hostReq_i) begin
					stateD = (hostRegion_i == fgVideoPkg::REGION_VRAM) ?
						fgVideoPkg::ST_WAIT_SLOT : fgVideoPkg::ST_WRITE;
				end
			fgVideoPkg::ST_WAIT_SLOT: if (rawBlank_i) stateD = fgVideoPkg::ST_ACK;
			fgVideoPkg::ST_WRITE:     stateD = fgVideoPkg::ST_ACK;
			fgVideoPkg::ST_ACK:       if (!hostReq_i) stateD = fgVideoPkg::ST_IDLE;
			default:                  stateD = fgVideoPkg::ST_IDLE;
		endcase
	end

	// request latch, host keeps these stable anyway
	always_ff @(posedge clk2_6MHZ) begin
		if (stateQ == fgVideoPkg::ST_IDLE && hostReq_i) begin
			regionQ  <= hostRegion_i;
			wrAddr_o <= hostAddr_i;
			wrData_o <= hostData_i;
		end
	end

	// VRAM write lands in the blank cycle itself, the fetch port is idle then
	assign vramWe_o = (stateQ == fgVideoPkg::ST_WAIT_SLOT) && rawBlank_i;
	assign charWe_o = (stateQ == fgVideoPkg::ST_WRITE) && (regionQ == fgVideoPkg::REGION_CHAR);
	assign ctrlWe   = (stateQ == fgVideoPkg::ST_WRITE) && (regionQ == fgVideoPkg::REGION_CTRL);

	assign hostAck_o = (stateQ == fgVideoPkg::ST_ACK);   // held until req drops

	//==================================================
	// control register
	//==================================================
	always_ff @(posedge clk2_6MHZ or negedge RAMB) begin
		if (!RAMB) begin
			colorBank_o <= 2'b00;
			charBank_o  <= 1'b0;
		end else if (ctrlWe) begin
			colorBank_o <= wrData_o[7:6];
			charBank_o  <= wrData_o[3];   // upper half of char ROM
		end
	end

endmodule

`default_nettype wire

//--- hw/tileFetch.sv
//==================================================
// VRAM and character ROM with the two stage fetch
// cycle 1 reads the tile code, cycle 2 the row byte;
// select bits and blank ride along with each pixel
//==================================================
`timescale 1ns/1ns
`default_nettype none

module tileFetch (
	input  wire                     clk2_6MHZ,
	input  fgVideoPkg::pixHT        pixH_i,
	input  fgVideoPkg::pixVT        pixV_i,
	input  wire                     charBank_i,
	input  wire                     vramWe_i,
	input  wire                     charWe_i,
	input  fgVideoPkg::charAddrT    wrAddr_i,
	input  fgVideoPkg::byteT        wrData_i,
	output fgVideoPkg::byteT        romByte_o,
	output logic [1:0]              pixSel_o,
	output logic                    blank_o
);

	localparam int VRAM_WORDS = 2048;
	localparam int CHAR_WORDS = 8192;

	fgVideoPkg::byteT vram    [VRAM_WORDS];
	fgVideoPkg::byteT charRom [CHAR_WORDS];

	fgVideoPkg::vramAddrT fetchAddr;
	fgVideoPkg::vramAddrT vramAddr;
	fgVideoPkg::charAddrT romAddr;

	// stage 1 side band
	fgVideoPkg::byteT tileCode;
	logic [2:0]       s1PixH;
	logic [2:0]       s1PixV;
	logic             s1Blank;

	logic             curBlank;

	assign curBlank  = fgVideoPkg::hBlankOf(pixH_i) | fgVideoPkg::vBlankOf(pixV_i);
	assign fetchAddr = {pixV_i[7:3], pixH_i[8:3]};   // 32 rows of 64 cells

	// single port, host write steals the port
	assign vramAddr = vramWe_i ? wrAddr_i[10:0] : fetchAddr;

	//==================================================
	// stage 1: tile code
	//==================================================
	always_ff @(posedge clk2_6MHZ) begin
		if (vramWe_i) begin
			vram[vramAddr] <= wrData_i;
		end
		tileCode <= vram[vramAddr];   // read-first
	end

	always_ff @(posedge clk2_6MHZ) begin
		s1PixH  <= pixH_i[2:0];
		s1PixV  <= pixV_i[2:0];
		s1Blank <= curBlank;
	end

	// each code spans 32 bytes, 4 pixels per byte
	assign romAddr = {charBank_i, tileCode[7:4], s1PixV, tileCode[3:0], s1PixH[2]};

	//==================================================
	// stage 2: row byte
	//==================================================
	always_ff @(posedge clk2_6MHZ) begin
		if (charWe_i) begin
			charRom[wrAddr_i] <= wrData_i;   // download port
		end
	end

	always_ff @(posedge clk2_6MHZ) begin
		romByte_o <= charRom[romAddr];
		pixSel_o  <= s1PixH[1:0];
		blank_o   <= s1Blank;
	end

endmodule

`default_nettype wire

//--- hw/layerMixer.sv
//==================================================
// picks the 2-bit pixel out of the row byte and
// forms the registered palette index
//==================================================
`timescale 1ns/1ns
`default_nettype none

module layerMixer (
	input  wire                    clk2_6MHZ,
	input  wire                    RAMB,
	input  fgVideoPkg::byteT       romByte_i,
	input  wire [1:0]              pixSel_i,
	input  wire                    blank_i,
	input  wire [1:0]              colorBank_i,
	output fgVideoPkg::colorIdxT   colorIndex_o
);

	logic [1:0] pixVal;

	// high plane in the upper nibble, low plane in the lower
	assign pixVal = {romByte_i[{1'b1, pixSel_i}], romByte_i[{1'b0, pixSel_i}]};

	always_ff @(posedge clk2_6MHZ or negedge RAMB) begin
		if (!RAMB) begin
			colorIndex_o <= '0;
		end else if (blank_i || pixVal == 2'b00) begin
			colorIndex_o <= '0;   // transparent or blanked
		end else begin
			colorIndex_o <= {1'b1, colorBank_i, pixVal};   // upper palette half
		end
	end

endmodule

`default_nettype wire

//--- hw/exerionFg.sv
//==================================================
// foreground text layer top
// timing, host write FSM, tile fetch and mixer;
// output is the palette index plus blank and sync
//==================================================
`timescale 1ns/1ns
`default_nettype none

module exerionFg (
	input  wire                      clk2_6MHZ,
	input  wire                      RAMB,
	input  wire                      hostReq_i,
	input  fgVideoPkg::hostRegionT   hostRegion_i,
	input  fgVideoPkg::charAddrT     hostAddr_i,
	input  fgVideoPkg::byteT         hostData_i,
	output logic                     hostAck_o,
	output fgVideoPkg::colorIdxT     colorIndex_o,
	output logic                     hBlank_o,
	output logic                     vBlank_o,
	output logic                     hSync_o,
	output logic                     vSync_o
);

	fgVideoPkg::pixHT     pixH;
	fgVideoPkg::pixVT     pixV;
	logic                 rawBlank;

	// host write path
	logic                 vramWe;
	logic                 charWe;
	fgVideoPkg::charAddrT wrAddr;
	fgVideoPkg::byteT     wrData;
	logic [1:0]           colorBank;
	logic                 charBank;

	// fetch to mixer
	fgVideoPkg::byteT     romByte;
	logic [1:0]           pixSel;
	logic                 fetchBlank;

	videoTiming timing (
		.clk2_6MHZ  (clk2_6MHZ),
		.RAMB       (RAMB),
		.pixH_o     (pixH),
		.pixV_o     (pixV),
		.rawBlank_o (rawBlank),
		.hBlank_o   (hBlank_o),
		.vBlank_o   (vBlank_o),
		.hSync_o    (hSync_o),
		.vSync_o    (vSync_o)
	);

	hostWriteFsm hostFsm (
		.clk2_6MHZ    (clk2_6MHZ),
		.RAMB         (RAMB),
		.hostReq_i    (hostReq_i),
		.hostRegion_i (hostRegion_i),
		.hostAddr_i   (hostAddr_i),
		.hostData_i   (hostData_i),
		.hostAck_o    (hostAck_o),
		.rawBlank_i   (rawBlank),
		.vramWe_o     (vramWe),
		.charWe_o     (charWe),
		.wrAddr_o     (wrAddr),
		.wrData_o     (wrData),
		.colorBank_o  (colorBank),
		.charBank_o   (charBank)
	);

	tileFetch fetch (
		.clk2_6MHZ  (clk2_6MHZ),
		.pixH_i     (pixH),
		.pixV_i     (pixV),
		.charBank_i (charBank),
		.vramWe_i   (vramWe),
		.charWe_i   (charWe),
		.wrAddr_i   (wrAddr),
		.wrData_i   (wrData),
		.romByte_o  (romByte),
		.pixSel_o   (pixSel),
		.blank_o    (fetchBlank)
	);

	layerMixer mixer (
		.clk2_6MHZ    (clk2_6MHZ),
		.RAMB         (RAMB),
		.romByte_i    (romByte),
		.pixSel_i     (pixSel),
		.blank_i      (fetchBlank),
		.colorBank_i  (colorBank),
		.colorIndex_o (colorIndex_o)
	);

endmodule

`default_nettype wire

//--- verification/exerionFg_chk.sv
//==================================================
// concurrent checks on the host handshake and on
// blank gating of the colour index, bound into the
// top level of the foreground layer
//==================================================
`timescale 1ns/1ns
`default_nettype none

module exerionFg_chk (
	input wire                    clk2_6MHZ,
	input wire                    RAMB,
	input wire                    hostReq_i,
	input wire                    hostAck_o,
	input fgVideoPkg::colorIdxT   colorIndex_o,
	input wire                    hBlank_o,
	input wire                    vBlank_o
);

	// ack only answers a pending request
	ackNeedsReq: assert property (@(posedge clk2_6MHZ) disable iff (!RAMB)
		$rose(hostAck_o) |-> hostReq_i)
		else $error("ack rose while no request was pending");

	// ack held until the FSM has seen req low
	ackFallsAfterReq: assert property (@(posedge clk2_6MHZ) disable iff (!RAMB)
		$fell(hostAck_o) |-> !$past(hostReq_i))
		else $error("ack fell while the request was still high");

	// nothing drawn inside blanking
	blankGivesZero: assert property (@(posedge clk2_6MHZ) disable iff (!RAMB)
		(hBlank_o || vBlank_o) |-> (colorIndex_o == 5'd0))
		else $error("colour index not zero during blanking");

endmodule

bind exerionFg exerionFg_chk chk (.*);

`default_nettype wire

//--- verification/exerionFgTb.sv
//==================================================
// foreground layer testbench that loads VRAM and
// char ROM over the host port, then compares whole
// frames against a model built from the colour rule
//==================================================
`timescale 1ns/1ns
`default_nettype none

module exerionFgTb;

	localparam int FRAME_CYCLES = 108544;
	// clear ~0.5 frame, align 1, two checked frames and one gap
	localparam int TIMEOUT_CYCLES = 6 * FRAME_CYCLES;
	localparam int NUM_TILES = 6;
	localparam int NUM_BANKS = 2;

	typedef struct packed {
		logic [4:0]       row;
		logic [5:0]       col;
		fgVideoPkg::byteT code;
		fgVideoPkg::byteT rowByte;
		logic             randRows;   // bank 0 rows from $random
	} tileEntryT;

	typedef struct packed {
		logic [1:0] colorBank;
		logic       charBank;
	} bankEntryT;

	logic                   clk2_6MHZ;
	logic                   RAMB;
	logic                   hostReq;
	fgVideoPkg::hostRegionT hostRegion;
	fgVideoPkg::charAddrT   hostAddr;
	fgVideoPkg::byteT       hostData;
	logic                   hostAck;
	fgVideoPkg::colorIdxT   colorIndex;
	logic                   hBlank, vBlank, hSync, vSync;

	// reference contents
	fgVideoPkg::byteT vramModel [2048];
	fgVideoPkg::byteT romModel  [8192];
	logic [1:0]       colorBankM;
	logic             charBankM;

	tileEntryT tiles [NUM_TILES];
	bankEntryT banks [NUM_BANKS];

	int seed;
	int cycles;
	int line, col;
	bit lineKnown;
	bit prevHB, prevVB, prevHS, prevVS;
	int lastHsRise, hsHigh, hbLow, visLines, vsLines;
	bit sawHsRise, sawHbFall, sawVbFall, sawVsFall;
	bit armed, checking;
	int framesChecked;

	exerionFg dut (
		.clk2_6MHZ    (clk2_6MHZ),
		.RAMB         (RAMB),
		.hostReq_i    (hostReq),
		.hostRegion_i (hostRegion),
		.hostAddr_i   (hostAddr),
		.hostData_i   (hostData),
		.hostAck_o    (hostAck),
		.colorIndex_o (colorIndex),
		.hBlank_o     (hBlank),
		.vBlank_o     (vBlank),
		.hSync_o      (hSync),
		.vSync_o      (vSync)
	);

	initial begin
		clk2_6MHZ = 1'b0;
		forever #5 clk2_6MHZ = ~clk2_6MHZ;
	end

	//==================================================
	// error reporting
	//==================================================
	task automatic reportMismatch(input string what);
		$display("Mismatch at %0t ns: %s", $time, what);
		$display("Checks failed");
		$fatal(1, "stopped at first error");
	endtask

	task automatic stopOnError(input string what);
		$display("Error: %s", what);
		$display("Checks failed");
		$fatal(1, "stopped at first error");
	endtask

	always @(posedge clk2_6MHZ) begin
		cycles++;
		if (cycles >= TIMEOUT_CYCLES) begin
			stopOnError("the run hit its cycle limit before finishing");
		end
	end

	// {bank, code hi, row, code lo, half}
	function automatic fgVideoPkg::charAddrT charAddr(input logic bank, input fgVideoPkg::byteT code,
			input logic [2:0] row, input logic half);
		return {bank, code[7:4], row, code[3:0], half};
	endfunction

	function automatic fgVideoPkg::colorIdxT expectedIndex(input int h, input int v);
		fgVideoPkg::pixHT     hv;
		fgVideoPkg::pixVT     vv;
		fgVideoPkg::byteT     code;
		fgVideoPkg::byteT     rb;
		int                   i;
		logic [1:0]           p;
		hv   = fgVideoPkg::pixHT'(h);
		vv   = fgVideoPkg::pixVT'(v);
		code = vramModel[{vv[7:3], hv[8:3]}];
		rb   = romModel[charAddr(charBankM, code, vv[2:0], hv[2])];
		i    = int'(hv[1:0]);
		p    = {rb[i+4], rb[i]};
		if (p == 2'b00) return 5'd0;   // transparent
		return {1'b1, colorBankM, p};
	endfunction

	//==================================================
	// four-phase host write
	//==================================================
	task automatic hostWrite(input fgVideoPkg::hostRegionT region, input int addr,
			input int data, output int waited);
		waited = 0;
		@(posedge clk2_6MHZ);
		hostReq    <= 1'b1;
		hostRegion <= region;
		hostAddr   <= fgVideoPkg::charAddrT'(addr);
		hostData   <= fgVideoPkg::byteT'(data);
		do begin
			@(negedge clk2_6MHZ);
			waited++;
		end while (!hostAck);
		@(posedge clk2_6MHZ);
		hostReq <= 1'b0;
		@(negedge clk2_6MHZ);
		assert (hostAck) else stopOnError("ack dropped before req low was seen");
		do @(negedge clk2_6MHZ); while (hostAck);
	endtask

	task automatic writeVram(input int addr, input fgVideoPkg::byteT data);
		int waited;
		hostWrite(fgVideoPkg::REGION_VRAM, addr, int'(data), waited);
		vramModel[addr] = data;
	endtask

	task automatic writeChar(input fgVideoPkg::charAddrT addr, input fgVideoPkg::byteT data);
		int waited;
		hostWrite(fgVideoPkg::REGION_CHAR, int'(addr), int'(data), waited);
		romModel[addr] = data;
	endtask

	task automatic writeCtrl(input logic [1:0] cBank, input logic chBank);
		int waited;
		hostWrite(fgVideoPkg::REGION_CTRL, 0, int'({cBank, 2'b00, chBank, 3'b000}), waited);
		colorBankM = cBank;
		charBankM  = chBank;
	endtask

	//==================================================
	// timing and pixel monitor sampled mid-cycle
	//==================================================
	always @(negedge clk2_6MHZ) begin
		if (RAMB) begin
			if (hBlank || vBlank) begin
				assert (colorIndex == 5'd0)
					else reportMismatch($sformatf("index %h inside blanking", colorIndex));
			end
			if (!vBlank && prevVB) begin   // frame starts at line 16
				line      = 15;
				lineKnown = 1;
				visLines  = 0;
				sawVbFall = 1;
				if (armed) checking = 1;
			end
			if (vBlank && !prevVB) begin
				if (sawVbFall) begin
					assert (visLines == 224)
						else reportMismatch($sformatf("%0d visible lines", visLines));
				end
				lineKnown = 0;
				if (checking) begin
					checking = 0;
					armed    = 0;
					framesChecked++;
				end
			end
			if (!hBlank && prevHB) begin   // column 90
				col       = 90;
				hbLow     = 1;
				sawHbFall = 1;
				if (lineKnown) line++;
				if (!vBlank) visLines++;
			end else if (!hBlank) begin
				col++;
				hbLow++;
			end
			if (hBlank && !prevHB && sawHbFall) begin
				assert (hbLow == 348)
					else reportMismatch($sformatf("hBlank low for %0d cycles", hbLow));
			end
			if (hSync && !prevHS) begin
				if (sawHsRise) begin
					assert (cycles - lastHsRise == 424)
						else reportMismatch($sformatf("hSync period %0d", cycles - lastHsRise));
				end
				sawHsRise  = 1;
				lastHsRise = cycles;
				hsHigh     = 0;
				if (!vSync) vsLines++;
			end
			if (hSync) hsHigh++;
			if (!hSync && prevHS) begin
				assert (hsHigh == 16)
					else reportMismatch($sformatf("hSync high for %0d cycles", hsHigh));
			end
			if (!vSync && prevVS) begin
				vsLines   = 0;
				sawVsFall = 1;
			end
			if (vSync && !prevVS && sawVsFall) begin
				assert (vsLines == 4)
					else reportMismatch($sformatf("vSync low for %0d lines", vsLines));
			end
			if (checking && !hBlank && !vBlank) begin
				assert (colorIndex == expectedIndex(col, line))
					else reportMismatch($sformatf("line %0d col %0d got %h expected %h",
						line, col, colorIndex, expectedIndex(col, line)));
			end
			prevHB = hBlank;
			prevVB = vBlank;
			prevHS = hSync;
			prevVS = vSync;
		end
	end

	//==================================================
	// main sequence
	//==================================================
	initial begin
		int waited;
		fgVideoPkg::byteT b;
		RAMB       = 1'b0;
		hostReq    = 1'b0;
		hostRegion = fgVideoPkg::REGION_VRAM;
		hostAddr   = '0;
		hostData   = '0;
		seed       = 32'hf38e_8ea7;
		cycles     = 0;
		prevHB     = 1;
		prevVB     = 1;
		prevHS     = 0;
		prevVS     = 1;
		colorBankM = 2'b00;
		charBankM  = 1'b0;

		tiles[0] = '{5'd2,  6'd11, 8'h21, 8'h50, 1'b0};   // left edge
		tiles[1] = '{5'd5,  6'd20, 8'h5a, 8'hc3, 1'b0};
		tiles[2] = '{5'd9,  6'd33, 8'h93, 8'h00, 1'b0};   // all transparent
		tiles[3] = '{5'd17, 6'd47, 8'hc4, 8'h00, 1'b1};
		tiles[4] = '{5'd29, 6'd54, 8'h0f, 8'h00, 1'b1};   // bottom right
		tiles[5] = '{5'd14, 6'd28, 8'hff, 8'ha5, 1'b0};
		banks[0] = '{2'b01, 1'b0};
		banks[1] = '{2'b10, 1'b1};

		repeat (8) @(posedge clk2_6MHZ);
		@(negedge clk2_6MHZ);
		assert (hostAck == 1'b0 && colorIndex == 5'd0)
			else reportMismatch("ack or colour index not zero after reset");
		@(posedge clk2_6MHZ);
		RAMB <= 1'b1;

		// blank screen with code 0 in every cell and empty code 0 rows in both halves
		for (int a = 0; a < 2048; a++) writeVram(a, 8'h00);
		for (int k = 0; k < 32; k++) begin
			writeChar(charAddr(k[4], 8'h00, k[3:1], k[0]), 8'h00);
		end

		for (int t = 0; t < NUM_TILES; t++) begin
			writeVram(int'({tiles[t].row, tiles[t].col}), tiles[t].code);
			for (int k = 0; k < 16; k++) begin
				b = tiles[t].randRows ? fgVideoPkg::byteT'($random(seed)) : tiles[t].rowByte;
				writeChar(charAddr(1'b0, tiles[t].code, k[3:1], k[0]), b);
				writeChar(charAddr(1'b1, tiles[t].code, k[3:1], k[0]),
					fgVideoPkg::byteT'($random(seed)));
			end
		end

		for (int n = 0; n < NUM_BANKS; n++) begin
			if (n > 0) begin
				// VRAM write from the middle of a visible line
				do @(negedge clk2_6MHZ); while (hBlank || vBlank || !lineKnown || col > 200);
				hostWrite(fgVideoPkg::REGION_VRAM, int'({5'd12, 6'd40}), int'(tiles[1].code),
					waited);
				vramModel[{5'd12, 6'd40}] = tiles[1].code;
				assert (waited > 10)
					else stopOnError("VRAM write did not wait for a blanking slot");
			end
			writeCtrl(banks[n].colorBank, banks[n].charBank);
			armed = 1;
			while (framesChecked < n + 1) @(negedge clk2_6MHZ);
		end

		$display("All checks passed");
		$finish;
	end

endmodule

`default_nettype wire

//--- exerionFg.f
hw/fgVideoPkg.sv
hw/videoTiming.sv
hw/hostWriteFsm.sv
hw/tileFetch.sv
hw/layerMixer.sv
hw/exerionFg.sv
verification/exerionFg_chk.sv
verification/exerionFgTb.sv

//--- run.sh
#!/bin/sh
# builds and runs the foreground layer testbench with Verilator
# exit status is non-zero when the simulation stops on an error

cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal \
	--top-module exerionFgTb \
	-f exerionFg.f \
	-o exerionFgSim &&
./obj_dir/exerionFgSim || exit 1
